// File: epb_wb_cfg.svh
`ifndef EPB_WB_CFG_SVH
`define EPB_WB_CFG_SVH

// data width of both the epb data bus and the wishbone data path
`define EPB_WB_DW 16

// wishbone byte address width
`define EPB_WB_AW 32

// region bases, compared against adr[31:16]
// register block sits at the bottom of the map
`define EPB_WB_REGS_BASE 16'h0000
// scratch ram right above it
`define EPB_WB_RAM_BASE 16'h0001

// scratch ram size in 16-bit words
`define EPB_WB_RAM_DEPTH 256

// read-only identifier in register word 0
`define EPB_WB_BOARD_ID 16'hB41F

`endif

// File: epb_wb_pkg.sv
`include "epb_wb_cfg.svh"

package epb_wb_pkg;

  // external processor bus, as seen at the pins
  // 49 bits, all sampled in the epb clock domain
  typedef struct packed {
    // chip select, low active, falling edge starts an access
    logic                  cs_n;
    // high for read, low for write
    logic                  r_w_n;
    // byte enables, low active, bit 1 is the upper byte
    logic [1:0]            be_n;
    // word address
    logic [22:0]           addr;
    // general purpose address extension
    logic [5:0]            addr_gp;
    // write data from the master
    logic [`EPB_WB_DW-1:0] wdata;
  } epb_req_t;

  // wishbone master side, single cycle strobe only
  typedef struct packed {
    logic                    cyc;
    logic                    stb;
    logic                    we;
    // byte lane select, high active
    logic [1:0]              sel;
    // byte address, bit 0 always zero
    logic [`EPB_WB_AW-1:0]   adr;
    // write data
    logic [`EPB_WB_DW-1:0]   dat;
  } wb_req_t;

  // wishbone slave answer
  // exactly one of ack and err is high, for one cycle
  typedef struct packed {
    logic                  ack;
    logic                  err;
    // read data, valid with ack
    logic [`EPB_WB_DW-1:0] dat;
  } wb_rsp_t;

endpackage

// File: epb_wb_bridge.sv
`include "epb_wb_cfg.svh"

module epb_wb_bridge (
  input  logic                  wb_clk_i,
  input  logic                  wb_rst_i,
  input  logic                  epb_clk_i,
  input  epb_wb_pkg::epb_req_t  epb_req_i,
  output logic [`EPB_WB_DW-1:0] epb_rdata_o,
  output logic                  epb_rdy_o,
  output epb_wb_pkg::wb_req_t   wb_req_o,
  input  epb_wb_pkg::wb_rsp_t   wb_rsp_i
);

  // epb side
  logic prev_cs_n;
  logic cs_fall;
  // access seen but not yet handed to the wb side
  logic cmnd_pend;
  logic cmnd_got;
  logic resp_ack;

  // wb side
  logic cmnd_ack;
  logic cmnd_fire;
  logic resp_got;
  logic wb_stb;
  logic [`EPB_WB_DW-1:0] rdata_q;

  // two flop synchronizers, bit 1 is the safe output
  // cmnd_got into the wb domain
  logic [1:0] cmnd_got_sync;
  // resp_ack into the wb domain
  logic [1:0] resp_ack_sync;
  // cmnd_ack into the epb domain
  logic [1:0] cmnd_ack_sync;
  // resp_got into the epb domain
  logic [1:0] resp_got_sync;

  // start of an access
  assign cs_fall = prev_cs_n & ~epb_req_i.cs_n;

  always_ff @(posedge epb_clk_i) begin
    if (wb_rst_i) begin
      cmnd_ack_sync <= 2'b00;
      resp_got_sync <= 2'b00;
    end else begin
      cmnd_ack_sync <= {cmnd_ack_sync[0], cmnd_ack};
      resp_got_sync <= {resp_got_sync[0], resp_got};
    end
  end

  always_ff @(posedge epb_clk_i) begin
    if (wb_rst_i) begin
      prev_cs_n <= 1'b1;
      cmnd_pend <= 1'b0;
      cmnd_got  <= 1'b0;
      resp_ack  <= 1'b0;
      epb_rdy_o <= 1'b0;
    end else begin
      prev_cs_n <= epb_req_i.cs_n;
      // four phase command toggle
      // a new flag waits until the previous ack has dropped
      if (cmnd_got) begin
        if (cmnd_ack_sync[1]) begin
          cmnd_got <= 1'b0;
        end
      end else if (cmnd_pend && !cmnd_ack_sync[1]) begin
        cmnd_got  <= 1'b1;
        cmnd_pend <= 1'b0;
      end
      if (cs_fall) begin
        cmnd_pend <= 1'b1;
      end
      // acknowledge follows the synchronized response flag
      resp_ack <= resp_got_sync[1];
      // ready rises once, on the first sight of the response
      if (resp_got_sync[1] && !resp_ack) begin
        epb_rdy_o <= 1'b1;
      end
      if (cs_fall) begin
        epb_rdy_o <= 1'b0;
      end
    end
  end

  // fire only on a fresh command with the response toggle idle
  // so the next ack or err can always raise resp_got
  assign cmnd_fire = cmnd_got_sync[1] & ~cmnd_ack & ~resp_got & ~resp_ack_sync[1];

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      cmnd_got_sync <= 2'b00;
      resp_ack_sync <= 2'b00;
      cmnd_ack      <= 1'b0;
      resp_got      <= 1'b0;
      wb_stb        <= 1'b0;
    end else begin
      cmnd_got_sync <= {cmnd_got_sync[0], cmnd_got};
      resp_ack_sync <= {resp_ack_sync[0], resp_ack};
      // one strobe cycle per command
      wb_stb <= cmnd_fire;
      // ack stays up until the command flag is seen low
      if (cmnd_fire) begin
        cmnd_ack <= 1'b1;
      end else if (!cmnd_got_sync[1]) begin
        cmnd_ack <= 1'b0;
      end
      // error responses complete the access too
      if (wb_rsp_i.ack || wb_rsp_i.err) begin
        resp_got <= 1'b1;
      end else if (resp_ack_sync[1]) begin
        resp_got <= 1'b0;
      end
    end
  end

  // read data, stable long before epb_rdy_o rises
  always_ff @(posedge wb_clk_i) begin
    if (wb_rsp_i.ack) begin
      rdata_q <= wb_rsp_i.dat;
    end
  end

  assign epb_rdata_o = rdata_q;

  // address, data and control are held by the master for the whole access
  always_comb begin
    wb_req_o.cyc = wb_stb;
    wb_req_o.stb = wb_stb;
    wb_req_o.we  = ~epb_req_i.r_w_n;
    wb_req_o.sel = ~epb_req_i.be_n;
    // word address shifted up to a byte address
    wb_req_o.adr = {2'b00, epb_req_i.addr_gp, epb_req_i.addr, 1'b0};
    wb_req_o.dat = epb_req_i.wdata;
  end

endmodule

// File: wb_addr_decoder.sv
`include "epb_wb_cfg.svh"

module wb_addr_decoder (
  input  logic                wb_clk_i,
  input  logic                wb_rst_i,
  input  epb_wb_pkg::wb_req_t wb_req_i,
  output epb_wb_pkg::wb_rsp_t wb_rsp_o,
  output epb_wb_pkg::wb_req_t regs_req_o,
  output epb_wb_pkg::wb_req_t ram_req_o,
  input  epb_wb_pkg::wb_rsp_t regs_rsp_i,
  input  epb_wb_pkg::wb_rsp_t ram_rsp_i,
  output logic                unmapped_o
);

  // upper address half picks the region
  logic [15:0] region;
  logic        hit_regs;
  logic        hit_ram;
  logic        access;
  // unmapped access, answered one cycle after stb
  logic        miss_q;

  assign region   = wb_req_i.adr[`EPB_WB_AW-1 -: 16];
  assign hit_regs = (region == `EPB_WB_REGS_BASE);
  assign hit_ram  = (region == `EPB_WB_RAM_BASE);
  assign access   = wb_req_i.cyc & wb_req_i.stb;

  // slaves share everything except the strobe
  always_comb begin
    regs_req_o     = wb_req_i;
    regs_req_o.stb = wb_req_i.stb & hit_regs;
    ram_req_o      = wb_req_i;
    ram_req_o.stb  = wb_req_i.stb & hit_ram;
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      miss_q <= 1'b0;
    end else begin
      miss_q <= access & ~hit_regs & ~hit_ram;
    end
  end

  // at most one slave answers in a cycle
  always_comb begin
    wb_rsp_o.ack = regs_rsp_i.ack | ram_rsp_i.ack;
    wb_rsp_o.err = miss_q | regs_rsp_i.err | ram_rsp_i.err;
    if (regs_rsp_i.ack) begin
      wb_rsp_o.dat = regs_rsp_i.dat;
    end else if (ram_rsp_i.ack) begin
      wb_rsp_o.dat = ram_rsp_i.dat;
    end else begin
      wb_rsp_o.dat = '0;
    end
  end

  // counted by the register block
  assign unmapped_o = miss_q;

endmodule

// File: wb_sys_regs.sv
`include "epb_wb_cfg.svh"

module wb_sys_regs (
  input  logic                wb_clk_i,
  input  logic                wb_rst_i,
  input  epb_wb_pkg::wb_req_t wb_req_i,
  output epb_wb_pkg::wb_rsp_t wb_rsp_o,
  input  logic                unmapped_i
);

  // word map, byte address bits 2:1
  localparam logic [1:0] WORD_ID      = 2'd0;
  localparam logic [1:0] WORD_SCRATCH = 2'd1;
  localparam logic [1:0] WORD_UNMAP   = 2'd2;

  logic                  access;
  logic                  wr;
  logic [1:0]            word;
  logic [`EPB_WB_DW-1:0] scratch_q;
  logic [`EPB_WB_DW-1:0] unmap_cnt_q;
  logic                  ack_q;
  logic [`EPB_WB_DW-1:0] rdata_q;

  assign access = wb_req_i.cyc & wb_req_i.stb;
  assign wr     = access & wb_req_i.we;
  assign word   = wb_req_i.adr[2:1];

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      scratch_q   <= '0;
      unmap_cnt_q <= '0;
      ack_q       <= 1'b0;
    end else begin
      ack_q <= access;
      // scratch written per byte lane
      if (wr && word == WORD_SCRATCH) begin
        for (int b = 0; b < 2; b++) begin
          if (wb_req_i.sel[b]) begin
            scratch_q[8*b +: 8] <= wb_req_i.dat[8*b +: 8];
          end
        end
      end
      // any write clears the counter
      if (wr && word == WORD_UNMAP) begin
        unmap_cnt_q <= '0;
      end else if (unmapped_i) begin
        unmap_cnt_q <= unmap_cnt_q + 1'b1;
      end
    end
  end

  // read mux, captured with the strobe
  always_ff @(posedge wb_clk_i) begin
    if (access) begin
      case (word)
        WORD_ID:      rdata_q <= `EPB_WB_BOARD_ID;
        WORD_SCRATCH: rdata_q <= scratch_q;
        WORD_UNMAP:   rdata_q <= unmap_cnt_q;
        default:      rdata_q <= '0;
      endcase
    end
  end

  // never errors, unused words read zero
  always_comb begin
    wb_rsp_o.ack = ack_q;
    wb_rsp_o.err = 1'b0;
    wb_rsp_o.dat = rdata_q;
  end

endmodule

// File: wb_scratch_ram.sv
`include "epb_wb_cfg.svh"

module wb_scratch_ram (
  input  logic                wb_clk_i,
  input  logic                wb_rst_i,
  input  epb_wb_pkg::wb_req_t wb_req_i,
  output epb_wb_pkg::wb_rsp_t wb_rsp_o
);

  // word index width, 8 bits for 256 words
  localparam int unsigned RAM_AW = $clog2(`EPB_WB_RAM_DEPTH);

  logic [`EPB_WB_DW-1:0] mem [`EPB_WB_RAM_DEPTH];
  logic [RAM_AW-1:0]     idx;
  logic                  access;
  logic                  ack_q;
  logic [`EPB_WB_DW-1:0] rdata_q;

  // byte address bit 0 is dropped
  assign idx    = wb_req_i.adr[RAM_AW:1];
  assign access = wb_req_i.cyc & wb_req_i.stb;

  // memory port, byte lane writes
  always_ff @(posedge wb_clk_i) begin
    if (access) begin
      // old contents on a write, nobody reads them
      rdata_q <= mem[idx];
      if (wb_req_i.we) begin
        for (int b = 0; b < 2; b++) begin
          if (wb_req_i.sel[b]) begin
            mem[idx][8*b +: 8] <= wb_req_i.dat[8*b +: 8];
          end
        end
      end
    end
  end

  // fixed one cycle answer
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  always_comb begin
    wb_rsp_o.ack = ack_q;
    wb_rsp_o.err = 1'b0;
    wb_rsp_o.dat = rdata_q;
  end

endmodule

// File: epb_wb_top.sv
`include "epb_wb_cfg.svh"

module epb_wb_top (
  input  logic                  wb_clk_i,
  input  logic                  wb_rst_i,
  input  logic                  epb_clk_i,
  input  epb_wb_pkg::epb_req_t  epb_req_i,
  output logic [`EPB_WB_DW-1:0] epb_rdata_o,
  output logic                  epb_rdy_o
);

  import epb_wb_pkg::*;

  // bridge to decoder
  wb_req_t bridge_req;
  wb_rsp_t bridge_rsp;
  // decoder to slaves
  wb_req_t regs_req;
  wb_rsp_t regs_rsp;
  wb_req_t ram_req;
  wb_rsp_t ram_rsp;
  // error pulse into the counter
  logic    unmapped;

  epb_wb_bridge i_bridge (
    .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i), .epb_clk_i(epb_clk_i),
    .epb_req_i(epb_req_i), .epb_rdata_o(epb_rdata_o), .epb_rdy_o(epb_rdy_o),
    .wb_req_o(bridge_req), .wb_rsp_i(bridge_rsp)
  );

  wb_addr_decoder i_decoder (
    .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
    .wb_req_i(bridge_req), .wb_rsp_o(bridge_rsp),
    .regs_req_o(regs_req), .ram_req_o(ram_req),
    .regs_rsp_i(regs_rsp), .ram_rsp_i(ram_rsp),
    .unmapped_o(unmapped)
  );

  wb_sys_regs i_regs (
    .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
    .wb_req_i(regs_req), .wb_rsp_o(regs_rsp), .unmapped_i(unmapped)
  );

  wb_scratch_ram i_ram (
    .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
    .wb_req_i(ram_req), .wb_rsp_o(ram_rsp)
  );

endmodule

// File: epb_wb_tb.sv
`include "epb_wb_cfg.svh"

module epb_wb_tb;
  timeunit 1ns;
  timeprecision 10ps;

  import epb_wb_pkg::*;

  // accesses issued over all five tests
  // sets the watchdog length
  localparam int N_ACCESS = 1 + 8 + 80 + 6 + 24;

  logic                  wb_clk_i = 1'b0;
  logic                  wb_rst_i;
  logic                  epb_clk_i = 1'b0;
  epb_req_t              epb_req_i;
  logic [`EPB_WB_DW-1:0] epb_rdata_o;
  logic                  epb_rdy_o;

  integer seed = 97858;
  int     n_tests = 0;
  int     n_errors = 0;

  // model of the register and ram map
  logic [15:0] scratch_m;
  logic [15:0] unmap_m;
  logic [15:0] ram_m [`EPB_WB_RAM_DEPTH];

  // finished reads waiting for the compare process
  logic [15:0] exp_q[$];
  logic [15:0] act_q[$];

  // wb clock 10 ns and epb clock 14 ns
  always #5 wb_clk_i = ~wb_clk_i;
  always #7 epb_clk_i = ~epb_clk_i;

  epb_wb_top i_epb_wb_top (
    .wb_clk_i(wb_clk_i),
    .wb_rst_i(wb_rst_i),
    .epb_clk_i(epb_clk_i),
    .epb_req_i(epb_req_i),
    .epb_rdata_o(epb_rdata_o),
    .epb_rdy_o(epb_rdy_o)
  );

  // byte lanes under low active enables
  function automatic logic [15:0] merge_bytes(logic [15:0] old, logic [15:0] dat,
                                              logic [1:0] be_n);
    logic [15:0] mask;
    mask = {{8{~be_n[1]}}, {8{~be_n[0]}}};
    return (old & ~mask) | (dat & mask);
  endfunction

  // expected read value of one access
  // upper address half picks the region
  function automatic logic [15:0] ref_read(logic [31:0] adr);
    if (adr[31:16] == `EPB_WB_REGS_BASE) begin
      // word select on byte address bits 2:1
      case (adr[2:1])
        2'd0:    return `EPB_WB_BOARD_ID;
        2'd1:    return scratch_m;
        2'd2:    return unmap_m;
        default: return 16'h0000;
      endcase
    end else if (adr[31:16] == `EPB_WB_RAM_BASE) begin
      return ram_m[adr[8:1]];
    end
    return 16'h0000;
  endfunction

  function automatic void update_model(logic we, logic [1:0] be_n, logic [31:0] adr,
                                       logic [15:0] dat);
    if (adr[31:16] == `EPB_WB_REGS_BASE) begin
      if (we && adr[2:1] == 2'd1) begin
        scratch_m = merge_bytes(scratch_m, dat, be_n);
      end
      // any write clears the counter
      if (we && adr[2:1] == 2'd2) begin
        unmap_m = 16'h0000;
      end
    end else if (adr[31:16] == `EPB_WB_RAM_BASE) begin
      if (we) begin
        ram_m[adr[8:1]] = merge_bytes(ram_m[adr[8:1]], dat, be_n);
      end
    end else begin
      // unmapped access answered with err and counted
      unmap_m = unmap_m + 16'd1;
    end
  endfunction

  task automatic check_value(string name, logic [15:0] expected, logic [15:0] actual);
    if (actual !== expected) begin
      $display("ERR %s expected 0x%04h got 0x%04h", name, expected, actual);
      n_errors++;
    end
  endtask

  // half a cycle after a read lands
  always @(negedge epb_clk_i) begin
    while (act_q.size() != 0) begin
      check_value("epb_rdata_o", exp_q.pop_front(), act_q.pop_front());
    end
  end

  // one epb access
  // wb byte address split into addr_gp and addr
  task automatic epb_access(logic we, logic [1:0] be_n, logic [31:0] adr, logic [15:0] dat);
    @(posedge epb_clk_i);
    epb_req_i.cs_n    <= 1'b0;
    epb_req_i.r_w_n   <= ~we;
    epb_req_i.be_n    <= be_n;
    epb_req_i.addr    <= adr[23:1];
    epb_req_i.addr_gp <= adr[29:24];
    epb_req_i.wdata   <= dat;
    // edge that sees cs_n low drops epb_rdy_o
    @(posedge epb_clk_i);
    @(posedge epb_clk_i);
    check_value("epb_rdy_o", 16'h0000, {15'd0, epb_rdy_o});
    while (!epb_rdy_o) begin
      @(posedge epb_clk_i);
    end
    epb_req_i.cs_n <= 1'b1;
    // error responses carry no data
    if (!we && (adr[31:16] == `EPB_WB_REGS_BASE || adr[31:16] == `EPB_WB_RAM_BASE)) begin
      exp_q.push_back(ref_read(adr));
      act_q.push_back(epb_rdata_o);
    end
    update_model(we, be_n, adr, dat);
    // cs_n stays high for two cycles until the next access lowers it
    @(posedge epb_clk_i);
  endtask

  task automatic finish_test(string name, int errs_before);
    n_tests++;
    // last reads still in the queue
    while (act_q.size() != 0) begin
      @(posedge epb_clk_i);
    end
    $display("test %0d %s: %s", n_tests, name, (n_errors == errs_before) ? "pass" : "fail");
  endtask

  initial begin
    int          e0;
    logic [1:0]  be_n;
    logic [7:0]  w;
    logic [7:0]  words [40];
    epb_req_i = '0;
    epb_req_i.cs_n = 1'b1;
    wb_rst_i = 1'b1;
    scratch_m = 16'h0000;
    unmap_m = 16'h0000;
    repeat (3) @(posedge wb_clk_i);
    wb_rst_i <= 1'b0;
    repeat (2) @(posedge epb_clk_i);

    // board id after reset
    e0 = n_errors;
    check_value("epb_rdy_o", 16'h0000, {15'd0, epb_rdy_o});
    epb_access(1'b0, 2'b00, 32'h0000_0000, 16'h0000);
    finish_test("reset and board id", e0);

    // scratch under every byte enable pattern
    e0 = n_errors;
    for (int p = 0; p < 4; p++) begin
      epb_access(1'b1, p[1:0], 32'h0000_0002, 16'($random(seed)));
      epb_access(1'b0, 2'b00, 32'h0000_0002, 16'h0000);
    end
    finish_test("scratch byte enables", e0);

    // random ram words written before any read
    e0 = n_errors;
    for (int i = 0; i < 40; i++) begin
      words[i] = 8'($random(seed));
      epb_access(1'b1, 2'b00, {`EPB_WB_RAM_BASE, 7'd0, words[i], 1'b0}, 16'($random(seed)));
    end
    for (int i = 0; i < 40; i++) begin
      epb_access(1'b0, 2'b00, {`EPB_WB_RAM_BASE, 7'd0, words[i], 1'b0}, 16'h0000);
    end
    finish_test("ram random words", e0);

    // unmapped regions with one reached through addr_gp
    e0 = n_errors;
    epb_access(1'b0, 2'b00, 32'h0002_0000, 16'h0000);
    epb_access(1'b1, 2'b00, 32'h0100_0004, 16'h1234);
    epb_access(1'b0, 2'b00, 32'h3FFF_FFFE, 16'h0000);
    epb_access(1'b0, 2'b00, 32'h0000_0004, 16'h0000);
    epb_access(1'b1, 2'b00, 32'h0000_0004, 16'($random(seed)));
    epb_access(1'b0, 2'b00, 32'h0000_0004, 16'h0000);
    finish_test("unmapped counter", e0);

    // regions alternate with each access right after ready
    e0 = n_errors;
    for (int i = 0; i < 6; i++) begin
      w = 8'($random(seed));
      be_n = 2'($random(seed));
      epb_access(1'b1, be_n, 32'h0000_0002, 16'($random(seed)));
      epb_access(1'b1, 2'b00, {`EPB_WB_RAM_BASE, 7'd0, w, 1'b0}, 16'($random(seed)));
      epb_access(1'b0, 2'b00, 32'h0000_0002, 16'h0000);
      epb_access(1'b0, 2'b00, {`EPB_WB_RAM_BASE, 7'd0, w, 1'b0}, 16'h0000);
    end
    finish_test("alternating regions", e0);

    $display("tests: %0d  errors: %0d", n_tests, n_errors);
    if (n_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // 2 us per access
  initial begin
    repeat (N_ACCESS) #2us;
    $display("watchdog expired: epb_rdy_o never rose for the access in progress");
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: list.f
+incdir+.
epb_wb_pkg.sv
epb_wb_bridge.sv
wb_addr_decoder.sv
wb_sys_regs.sv
wb_scratch_ram.sv
epb_wb_top.sv
epb_wb_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps -Wno-fatal \
  --top-module epb_wb_tb -f list.f --Mdir obj_dir -o epb_wb_sim

./obj_dir/epb_wb_sim | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
  echo "simulation failed"
  exit 1
fi

if ! grep -q "NO ERRORS" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

echo "simulation passed"
